// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - include_dirs:
      - logic
    files:
      - logic/led_pkg.sv
      - logic/led_bus_port.sv
      - logic/led_frame_ram.sv
      - logic/led_scan_driver.sv
      - logic/led_matrix_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/led_matrix_checker.sv
      - verification/led_matrix_tb.sv

// ==== list.f ====
+incdir+logic
logic/led_pkg.sv
logic/led_bus_port.sv
logic/led_frame_ram.sv
logic/led_scan_driver.sv
logic/led_matrix_top.sv
verification/led_matrix_checker.sv
verification/led_matrix_tb.sv

// ==== logic/led_bus_port.sv ====
`timescale 1ns/1ns
`include "led_consts.svh"

module led_bus_port import led_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  led_bus_req_t bus_i,
  output led_bus_rsp_t bus_o,
  output led_ram_wr_t  ram_wr_o,
  input  led_pixel_t   ram_rdata_i
);

  logic select;
  logic stage1_q;
  logic stage2_q;

  assign select = bus_i.cyc & bus_i.stb;

  // memory access follows the active cycle directly
  always_comb begin
    ram_wr_o.en    = select;
    ram_wr_o.we    = select & bus_i.we;
    ram_wr_o.be    = bus_i.sel[2:0];   // lane 3 ignored
    ram_wr_o.addr  = bus_i.adr;
    ram_wr_o.wdata = bus_i.dat[23:0];
  end

  // two-stage select delay, second stage needs select still held
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      stage1_q <= 1'b0;
      stage2_q <= 1'b0;
    end else begin
      stage1_q <= select;
      stage2_q <= stage1_q & select;
    end
  end

  // registered ram pixel, zero-extended
  always_comb begin
    bus_o.ack = stage2_q;
    bus_o.dat = {8'h00, ram_rdata_i};
  end

  // ack drops one cycle after the master releases the bus
  assert property (@(posedge clk_i) disable iff (rst_i)
    bus_o.ack |-> $past(bus_i.cyc))
    else $error("ack without cyc in the cycle before");

endmodule

// ==== logic/led_consts.svh ====
`ifndef LED_CONSTS_SVH
`define LED_CONSTS_SVH

// panel geometry, 32x16 with 1/8 scan
`define LED_COLS 32
`define LED_ROWS 8

// frame address is {half, row, col}
`define LED_ADDR_W 9

// bit planes per colour channel
`define LED_PLANES 8

// output-enable counter
`define LED_DELAY_W 16

// oe length of plane 0 in cycles, raise for real panels
`define LED_PLANE_UNIT 1

`endif

// ==== logic/led_frame_ram.sv ====
`timescale 1ns/1ns
`include "led_consts.svh"

module led_frame_ram import led_pkg::*; (
  input  logic                   clk_i,
  input  led_ram_wr_t            ram_wr_i,
  output led_pixel_t             ram_rdata_o,
  input  logic [`LED_ADDR_W-1:0] scan_addr_i,
  output led_pixel_t             scan_pixel_o
);

  localparam int DEPTH = 1 << `LED_ADDR_W;

  led_pixel_t mem [DEPTH];
  logic       wr_en;

  assign wr_en = ram_wr_i.en & ram_wr_i.we;

  // bus side, one enable per colour byte
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      if (ram_wr_i.be[2]) begin
        mem[ram_wr_i.addr].r <= ram_wr_i.wdata.r;
      end
      if (ram_wr_i.be[1]) begin
        mem[ram_wr_i.addr].g <= ram_wr_i.wdata.g;
      end
      if (ram_wr_i.be[0]) begin
        mem[ram_wr_i.addr].b <= ram_wr_i.wdata.b;
      end
    end
  end

  // bus side readback
  always_ff @(posedge clk_i) begin
    if (ram_wr_i.en) begin
      ram_rdata_o <= mem[ram_wr_i.addr];
    end
  end

  // scan side, sees the old value on a same-cycle write
  always_ff @(posedge clk_i) begin
    scan_pixel_o <= mem[scan_addr_i];
  end

  assert property (@(posedge clk_i)
    ram_wr_i.en |-> !$isunknown(ram_wr_i.addr))
    else $error("frame memory access with unknown address");

endmodule

// ==== logic/led_matrix_top.sv ====
`timescale 1ns/1ns
`include "led_consts.svh"

module led_matrix_top import led_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  led_bus_req_t bus_i,
  output led_bus_rsp_t bus_o,
  output led_panel_t   panel_o
);

  led_ram_wr_t            ram_wr;
  led_pixel_t             ram_rdata;
  logic [`LED_ADDR_W-1:0] scan_addr;
  led_pixel_t             scan_pixel;

  // producer
  led_bus_port u_bus_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_i       (bus_i),
    .bus_o       (bus_o),
    .ram_wr_o    (ram_wr),
    .ram_rdata_i (ram_rdata)
  );

  // buffer
  led_frame_ram u_frame_ram (
    .clk_i        (clk_i),
    .ram_wr_i     (ram_wr),
    .ram_rdata_o  (ram_rdata),
    .scan_addr_i  (scan_addr),
    .scan_pixel_o (scan_pixel)
  );

  // consumer
  led_scan_driver u_scan_driver (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .scan_addr_o  (scan_addr),
    .scan_pixel_i (scan_pixel),
    .panel_o      (panel_o)
  );

endmodule

// ==== logic/led_pkg.sv ====
`include "led_consts.svh"

package led_pkg;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } led_pixel_t;

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [3:0]             sel;
    logic [`LED_ADDR_W-1:0] adr;
    logic [31:0]            dat;
  } led_bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } led_bus_rsp_t;

  typedef struct packed {
    logic                   en;
    logic                   we;
    logic [2:0]             be;    // red, green, blue
    logic [`LED_ADDR_W-1:0] addr;
    led_pixel_t             wdata;
  } led_ram_wr_t;

  typedef struct packed {
    logic [2:0] rgb0;   // upper half, red msb
    logic [2:0] rgb1;   // lower half
    logic [2:0] row;
    logic       sclk;
    logic       latch;
    logic       oe_n;
  } led_panel_t;

  typedef enum logic [2:0] {
    IDLE,
    READ1,
    READ2,
    CLOCK,
    LATCH,
    DELAY
  } led_scan_state_e;

endpackage

// ==== logic/led_scan_driver.sv ====
`timescale 1ns/1ns
`include "led_consts.svh"

module led_scan_driver import led_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  output logic [`LED_ADDR_W-1:0] scan_addr_o,
  input  led_pixel_t             scan_pixel_i,
  output led_panel_t             panel_o
);

  localparam int COL_W   = $clog2(`LED_COLS);
  localparam int ROW_W   = $clog2(`LED_ROWS);
  localparam int PLANE_W = $clog2(`LED_PLANES);

  localparam logic [PLANE_W-1:0]      TOP_PLANE = PLANE_W'(`LED_PLANES - 1);
  localparam logic [`LED_DELAY_W-1:0] UNIT      = `LED_DELAY_W'(`LED_PLANE_UNIT);

  led_scan_state_e         state_q;
  logic [COL_W-1:0]        col_q;
  logic [ROW_W-1:0]        row_q;
  logic                    half_q;
  logic [PLANE_W-1:0]      plane_q;
  logic [`LED_DELAY_W-1:0] delay_q;
  logic [2:0]              rgb0_q;
  logic [2:0]              rgb1_q;
  logic [2:0]              plane_bits;

  assign scan_addr_o = {half_q, row_q, col_q};

  // current plane bit of each colour, red first
  assign plane_bits = {scan_pixel_i.r[plane_q],
                       scan_pixel_i.g[plane_q],
                       scan_pixel_i.b[plane_q]};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      col_q   <= '0;
      row_q   <= '0;
      half_q  <= 1'b0;
      plane_q <= TOP_PLANE;
      delay_q <= '0;
      rgb0_q  <= '0;
      rgb1_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin                     // upper address out
          half_q  <= 1'b1;
          state_q <= READ1;
        end
        READ1: begin                    // lower address out
          rgb0_q  <= plane_bits;
          half_q  <= 1'b0;
          state_q <= READ2;
        end
        READ2: begin
          rgb1_q  <= plane_bits;
          col_q   <= col_q + 1'b1;
          state_q <= CLOCK;
        end
        CLOCK: begin
          // column counter wrapped, row fully shifted
          if (col_q == '0) begin
            state_q <= LATCH;
          end else begin
            state_q <= IDLE;
          end
        end
        LATCH: begin
          delay_q <= (UNIT << plane_q) - 1'b1;   // binary plane weight
          plane_q <= plane_q - 1'b1;
          state_q <= DELAY;
        end
        DELAY: begin
          if (delay_q == '0) begin
            // plane already wrapped to the top after plane 0
            if (plane_q == TOP_PLANE) begin
              row_q <= row_q + 1'b1;
            end
            state_q <= IDLE;
          end else begin
            delay_q <= delay_q - 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_comb begin
    panel_o.rgb0  = rgb0_q;
    panel_o.rgb1  = rgb1_q;
    panel_o.row   = row_q;
    panel_o.sclk  = (state_q == CLOCK);
    panel_o.latch = (state_q == LATCH);
    panel_o.oe_n  = (state_q != DELAY);
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    !(panel_o.sclk && panel_o.latch))
    else $error("sclk and latch high together");

  // outputs only come on right after a row is latched
  assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(panel_o.oe_n) |-> $past(panel_o.latch))
    else $error("oe_n low outside the delay period");

endmodule

// ==== verification/led_matrix_checker.sv ====
`timescale 1ns/1ns
`include "led_consts.svh"

module led_matrix_checker import led_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         check_en_i,
  input  led_bus_req_t req_i,
  input  led_bus_rsp_t rsp_i,
  input  led_panel_t   panel_i,
  output int           errors_o,
  output int           frames_o
);

  led_pixel_t             model_mem [1 << `LED_ADDR_W];
  logic                   active;
  logic                   active_q;
  logic                   pending;
  int                     edge_cnt;
  logic                   req_we;
  logic [`LED_ADDR_W-1:0] req_adr;
  logic [31:0]            exp_dat;
  int                     col;        // sclk pulses since the last latch
  int                     plane;
  int                     row;
  int                     lat_plane;  // plane whose oe period comes next
  logic                   latched;
  int                     low_cnt;
  int                     up_adr;
  int                     dn_adr;
  logic [2:0]             exp_rgb0;
  logic [2:0]             exp_rgb1;
  int                     err_cnt = 0;
  int                     frame_cnt = 0;

  assign active   = req_i.cyc & req_i.stb;
  assign errors_o = err_cnt;
  assign frames_o = frame_cnt;

  // one bit per colour, red first
  function automatic logic [2:0] bit_of_plane(input led_pixel_t p, input int pl);
    return {p.r[pl], p.g[pl], p.b[pl]};
  endfunction

  // bus side, sampled on the rising edge
  always @(posedge clk_i) begin
    if (rst_i) begin
      active_q = 1'b0;
      pending  = 1'b0;
      edge_cnt = 0;
    end else begin
      if (active && req_i.we) begin
        if (req_i.sel[2]) model_mem[req_i.adr].r = req_i.dat[23:16];
        if (req_i.sel[1]) model_mem[req_i.adr].g = req_i.dat[15:8];
        if (req_i.sel[0]) model_mem[req_i.adr].b = req_i.dat[7:0];
      end
      if (pending) begin
        edge_cnt++;
        if (rsp_i.ack) begin
          if (edge_cnt != 2) begin
            $display("protocol error at %0t: ack came %0d edges after the strobe, expected 2",
                     $time, edge_cnt);
            err_cnt++;
          end
          if (!req_we) begin
            exp_dat = {8'h00, model_mem[req_adr]};
            if (rsp_i.dat !== exp_dat) begin
              $display("FAILED @%0t: read of address %0d returned %h, expected %h",
                       $time, req_adr, rsp_i.dat, exp_dat);
              err_cnt++;
            end
          end
          pending = 1'b0;
        end else if (edge_cnt >= 2) begin
          $display("protocol error at %0t: no ack two edges after the strobe", $time);
          err_cnt++;
          pending = 1'b0;
        end
      end else if (rsp_i.ack) begin
        $display("protocol error at %0t: ack without a bus request", $time);
        err_cnt++;
      end
      if (active && !active_q) begin
        pending  = 1'b1;
        edge_cnt = 0;
        req_we   = req_i.we;
        req_adr  = req_i.adr;
      end
      active_q = active;
    end
  end

  // panel side
  always @(posedge clk_i) begin
    if (rst_i) begin
      col       = 0;
      plane     = `LED_PLANES - 1;
      row       = 0;
      lat_plane = `LED_PLANES - 1;
      latched   = 1'b0;
      low_cnt   = 0;
    end else begin
      if (panel_i.sclk) begin
        if (panel_i.row !== 3'(row)) begin
          $display("FAILED @%0t: row %0d on sclk, expected %0d", $time, panel_i.row, row);
          err_cnt++;
        end
        if (check_en_i && col < `LED_COLS) begin
          up_adr   = row * `LED_COLS + col;                // upper half
          dn_adr   = up_adr + `LED_ROWS * `LED_COLS;
          exp_rgb0 = bit_of_plane(model_mem[up_adr], plane);
          exp_rgb1 = bit_of_plane(model_mem[dn_adr], plane);
          if (panel_i.rgb0 !== exp_rgb0 || panel_i.rgb1 !== exp_rgb1) begin
            $display("FAILED @%0t: col %0d row %0d plane %0d rgb %b %b, expected %b %b",
                     $time, col, row, plane, panel_i.rgb0, panel_i.rgb1, exp_rgb0, exp_rgb1);
            err_cnt++;
          end
        end
        col++;
      end
      if (panel_i.latch) begin
        if (col != `LED_COLS) begin
          $display("protocol error at %0t: latch after %0d sclk pulses instead of %0d",
                   $time, col, `LED_COLS);
          err_cnt++;
        end
        col       = 0;
        lat_plane = plane;
        plane     = (plane == 0) ? `LED_PLANES - 1 : plane - 1;
        latched   = 1'b1;
      end
      if (!panel_i.oe_n) begin
        if (!latched && low_cnt == 0) begin
          $display("protocol error at %0t: oe_n went low without a latch before it", $time);
          err_cnt++;
        end
        latched = 1'b0;
        low_cnt++;
      end else if (low_cnt != 0) begin
        if (low_cnt != (`LED_PLANE_UNIT << lat_plane)) begin
          $display("FAILED @%0t: oe_n low for %0d cycles on plane %0d, expected %0d",
                   $time, low_cnt, lat_plane, `LED_PLANE_UNIT << lat_plane);
          err_cnt++;
        end
        low_cnt = 0;
        if (lat_plane == 0) begin
          row = (row + 1) % `LED_ROWS;
          if (row == 0) frame_cnt++;
        end
      end
    end
  end

endmodule

// ==== verification/led_matrix_tb.sv ====
`timescale 1ns/1ns
`include "led_consts.svh"

module led_matrix_tb import led_pkg::*; ();

  localparam int DEPTH         = 1 << `LED_ADDR_W;
  localparam int RANDOM_OPS    = 400;
  localparam int ACK_TIMEOUT   = 20;
  localparam int LATCH_TIMEOUT = 2000;
  localparam int FRAME_TIMEOUT = 40000;

  logic         clk_i;
  logic         rst_i;
  led_bus_req_t bus_i;
  led_bus_rsp_t bus_o;
  led_panel_t   panel_o;
  logic         scan_check_en;
  int           check_errors;
  int           frames;
  int           timeouts;
  logic [31:0]  lcg_state;

  led_matrix_top u_dut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .bus_i   (bus_i),
    .bus_o   (bus_o),
    .panel_o (panel_o)
  );

  led_matrix_checker u_checker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .check_en_i (scan_check_en),
    .req_i      (bus_i),
    .rsp_i      (bus_o),
    .panel_i    (panel_o),
    .errors_o   (check_errors),
    .frames_o   (frames)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];   // upper bits, the low ones cycle fast
  endfunction

  // called on a falling edge, returns on a falling edge after one idle cycle
  task automatic bus_access(input logic we, input logic [3:0] sel,
                            input logic [`LED_ADDR_W-1:0] adr, input logic [31:0] dat);
    int waited;
    waited    = 0;
    bus_i.cyc = 1'b1;
    bus_i.stb = 1'b1;
    bus_i.we  = we;
    bus_i.sel = sel;
    bus_i.adr = adr;
    bus_i.dat = dat;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!bus_o.ack && waited < ACK_TIMEOUT);
    if (!bus_o.ack) begin
      $display("timeout at %0t: no ack for the access to address %0d", $time, adr);
      timeouts++;
    end
    bus_i = '0;
    @(negedge clk_i);
  endtask

  initial begin
    int          a;
    int          i;
    int          waited;
    int          start_frames;
    logic [15:0] r;
    logic [15:0] hi;
    logic [15:0] lo;
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    bus_i         = '0;
    scan_check_en = 1'b0;
    timeouts      = 0;
    lcg_state     = 32'd66088;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    for (a = 0; a < DEPTH; a++) begin   // whole frame, all bytes
      hi = rand16();
      lo = rand16();
      bus_access(1'b1, 4'hf, `LED_ADDR_W'(a), {hi, lo});
    end
    for (i = 0; i < RANDOM_OPS; i++) begin
      r  = rand16();
      hi = rand16();
      lo = rand16();
      bus_access(r[0], r[4:1], r[`LED_ADDR_W+4:5], {hi, lo});
    end
    for (a = 0; a < DEPTH; a++) begin
      bus_access(1'b0, 4'h0, `LED_ADDR_W'(a), 32'h0);
    end

    // frame is stable from the next latch on
    waited = 0;
    while (!panel_o.latch && waited < LATCH_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!panel_o.latch) begin
      $display("timeout at %0t: no latch pulse after the last write", $time);
      timeouts++;
    end
    scan_check_en = 1'b1;

    // three wraps give at least two full frames
    start_frames = frames;
    waited       = 0;
    while (frames < start_frames + 3 && waited < FRAME_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (frames < start_frames + 3) begin
      $display("timeout at %0t: panel did not finish two full frames", $time);
      timeouts++;
    end

    $display("check errors: %0d, timeouts: %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
